// File: hw/gpio_pkg.sv
// shared constants for the apb gpio block
// address width, register offsets and reset value

package gpio_pkg;

  // ------------------------------------------------------------------------
  // apb address space
  // ------------------------------------------------------------------------

  localparam int gpio_addr_width = 6;       // 64 byte window

  // ------------------------------------------------------------------------
  // register offsets
  // ------------------------------------------------------------------------

  // 1 sets a pin to input mode and 0 to output mode
  localparam logic [gpio_addr_width-1:0] gpr_direction_mode = 6'h04;

  // driver enable per pin
  localparam logic [gpio_addr_width-1:0] gpr_output_enable  = 6'h08;

  // level driven on output pins
  localparam logic [gpio_addr_width-1:0] gpr_output_value   = 6'h0C;

  // synchronized pin level, read only
  localparam logic [gpio_addr_width-1:0] gpr_input_value    = 6'h10;

  // sticky rising edge flags, read only, cleared on read
  localparam logic [gpio_addr_width-1:0] gpr_int_status     = 6'h20;

  // ------------------------------------------------------------------------
  // reset value
  // ------------------------------------------------------------------------

  // every register comes up zero
  // so all pins start as disabled outputs
  localparam logic [31:0] gprv_reset_value = 32'h0000_0000;

endpackage : gpio_pkg

// File: hw/apb_gpio_port.sv
// apb3 slave front end for the gpio register unit
// turns bus phases into register strobes, wait state and error

`timescale 1ns/1ps

module apb_gpio_port
(
  input  logic                                pclk14,
  input  logic                                n_reset14,   // async, active low
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [gpio_pkg::gpio_addr_width-1:0] paddr,
  input  logic [31:0]                         pwdata,
  output logic [31:0]                         prdata,
  output logic                                pready,
  output logic                                pslverr,
  output logic                                reg_read,    // one cycle strobe
  output logic                                reg_write,   // one cycle strobe
  output logic [gpio_pkg::gpio_addr_width-1:0] reg_addr,
  output logic [31:0]                         reg_wdata,
  input  logic [31:0]                         reg_rdata    // registered in subunit
);

  import gpio_pkg::*;

  logic access_first;   // first access cycle of a transfer
  logic addr_legal;     // one of the five offsets
  logic write_legal;    // writable offset
  logic rd_wait;        // read wait cycle flag
  logic rd_err;         // errored read, reported with rd_wait

  // ------------------------------------------------------------------------
  // offset decode
  // ------------------------------------------------------------------------

  always_comb
  begin
    addr_legal = (paddr == gpr_direction_mode) ||
                 (paddr == gpr_output_enable)  ||
                 (paddr == gpr_output_value)   ||
                 (paddr == gpr_input_value)    ||
                 (paddr == gpr_int_status);
    // status and input value are read only
    write_legal = (paddr == gpr_direction_mode) ||
                  (paddr == gpr_output_enable)  ||
                  (paddr == gpr_output_value);
  end

  assign access_first = psel & penable & ~rd_wait;

  // strobes only for legal accesses
  assign reg_write = access_first & pwrite & write_legal;
  assign reg_read  = access_first & ~pwrite & addr_legal;
  assign reg_addr  = paddr;
  assign reg_wdata = pwdata;

  // read wait state tracking
  always_ff @(posedge pclk14 or negedge n_reset14)
  begin
    if (!n_reset14)
    begin
      rd_wait <= 1'b0;
      rd_err  <= 1'b0;
    end
    else
    begin
      rd_wait <= access_first & ~pwrite;                // one wait per read
      rd_err  <= access_first & ~pwrite & ~addr_legal;  // unmapped read
    end
  end

  // writes finish in the first access cycle, reads one cycle later
  assign pready  = (access_first & pwrite) | rd_wait;
  assign pslverr = (access_first & pwrite & ~write_legal) | rd_err;

  // subunit returns zero unless a legal read was strobed
  assign prdata  = reg_rdata;

endmodule : apb_gpio_port

// File: hw/gpio_input_sync.sv
// pin input chain for the gpio block
// two flop synchronizer, capture register and rising edge detect

`timescale 1ns/1ps

module gpio_input_sync
#(
  parameter int gpio_width = 16             // number of pins
)
(
  input  logic                  pclk14,
  input  logic                  n_reset14,     // async, active low
  input  logic [gpio_width-1:0] pin_in,        // raw pins, async to pclk14
  output logic [gpio_width-1:0] input_value,   // captured pin level
  output logic [gpio_width-1:0] rise_event     // one cycle per rising edge
);

  logic [gpio_width-1:0] sync_one;   // first flop, may go metastable
  logic [gpio_width-1:0] sync_two;   // second flop, settled

  // ------------------------------------------------------------------------
  // metastability chain
  // ------------------------------------------------------------------------

  always_ff @(posedge pclk14 or negedge n_reset14)
  begin
    if (!n_reset14)
    begin
      sync_one <= '0;
      sync_two <= '0;
    end
    else
    begin
      sync_one <= pin_in;     // stage one at the pins
      sync_two <= sync_one;   // stage two
    end
  end

  // capture stage
  // input_value lags sync_two by one edge
  always_ff @(posedge pclk14 or negedge n_reset14)
  begin
    if (!n_reset14)
      input_value <= '0;
    else
      input_value <= sync_two;   // third edge from the pin
  end

  // ------------------------------------------------------------------------
  // edge detect
  // ------------------------------------------------------------------------

  // new level high, captured level still low
  // clears itself once the capture stage catches up
  assign rise_event = sync_two & ~input_value;

endmodule : gpio_input_sync

// File: hw/gpio_lite_subunit.sv
// gpio register unit
// direction, output enable, output value and interrupt status registers
// registered read mux and pin driver logic

`timescale 1ns/1ps

module gpio_lite_subunit
#(
  parameter int gpio_width = 16              // number of pins, 8 to 32
)
(
  input  logic                                pclk14,
  input  logic                                n_reset14,      // async, active low
  input  logic                                reg_read,       // from port stage
  input  logic                                reg_write,      // from port stage
  input  logic [gpio_pkg::gpio_addr_width-1:0] reg_addr,
  input  logic [31:0]                         reg_wdata,
  output logic [31:0]                         reg_rdata,      // valid cycle after read
  input  logic [gpio_width-1:0]               input_value,    // captured pins
  input  logic [gpio_width-1:0]               rise_event,     // from edge detect
  input  logic                                test_tristate,  // forces drivers off
  output logic [gpio_width-1:0]               interrupt,      // one bit per pin
  output logic [gpio_width-1:0]               pin_out,
  output logic [gpio_width-1:0]               pin_oe_n        // active low enable
);

  import gpio_pkg::*;

  logic [gpio_width-1:0] direction_mode;   // 1 input, 0 output
  logic [gpio_width-1:0] output_enable;    // driver active
  logic [gpio_width-1:0] output_value;     // level to drive
  logic [gpio_width-1:0] int_status;       // sticky rise flags
  logic [gpio_width-1:0] int_trigger;      // qualified rise events
  logic [gpio_width-1:0] rd_mux;           // selected register
  logic [gpio_width-1:0] rdata_q;          // read data register
  logic [gpio_width-1:0] wr_data;          // low bits of bus data
  logic                  status_clear;     // read of status offset

  assign wr_data = reg_wdata[gpio_width-1:0];

  // ------------------------------------------------------------------------
  // writable registers
  // ------------------------------------------------------------------------

  always_ff @(posedge pclk14 or negedge n_reset14)
  begin
    if (!n_reset14)
    begin
      direction_mode <= gprv_reset_value[gpio_width-1:0];
      output_enable  <= gprv_reset_value[gpio_width-1:0];
      output_value   <= gprv_reset_value[gpio_width-1:0];
    end
    else if (reg_write)
    begin
      // port stage only strobes legal offsets
      case (reg_addr)
        gpr_direction_mode: direction_mode <= wr_data;
        gpr_output_enable:  output_enable  <= wr_data;
        gpr_output_value:   output_value   <= wr_data;
        default:            ;                           // read only offsets
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // interrupt status
  // ------------------------------------------------------------------------

  // output mode pins never flag
  assign int_trigger  = rise_event & direction_mode;
  assign status_clear = reg_read && (reg_addr == gpr_int_status);

  // set wins over clear in the same cycle
  always_ff @(posedge pclk14 or negedge n_reset14)
  begin
    if (!n_reset14)
      int_status <= gprv_reset_value[gpio_width-1:0];
    else
      int_status <= (int_status & ~{gpio_width{status_clear}}) | int_trigger;
  end

  assign interrupt = int_status;

  // ------------------------------------------------------------------------
  // read path
  // ------------------------------------------------------------------------

  always_comb
  begin
    case (reg_addr)
      gpr_direction_mode: rd_mux = direction_mode;
      gpr_output_enable:  rd_mux = output_enable;
      gpr_output_value:   rd_mux = output_value;
      gpr_input_value:    rd_mux = input_value;
      gpr_int_status:     rd_mux = int_status;   // value before the clear
      default:            rd_mux = '0;
    endcase
  end

  // zero whenever the previous cycle had no read
  always_ff @(posedge pclk14 or negedge n_reset14)
  begin
    if (!n_reset14)
      rdata_q <= '0;
    else if (reg_read)
      rdata_q <= rd_mux;
    else
      rdata_q <= '0;
  end

  // upper bus bits read as zero
  assign reg_rdata = 32'(rdata_q);

  // ------------------------------------------------------------------------
  // pin drivers
  // ------------------------------------------------------------------------

  assign pin_out = output_value;

  // driver on only when enabled, in output mode and not in test
  assign pin_oe_n = ~(output_enable & ~direction_mode) | {gpio_width{test_tristate}};

endmodule : gpio_lite_subunit

// File: hw/gpio_lite.sv
// top level of the apb gpio block
// wires the apb port stage, the input chain and the register unit

`timescale 1ns/1ps

module gpio_lite
#(
  parameter int gpio_width = 16                   // number of pins
)
(
  input  logic                                pclk14,
  input  logic                                n_reset14,     // async, active low
  // apb3 slave
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [gpio_pkg::gpio_addr_width-1:0] paddr,
  input  logic [31:0]                         pwdata,
  output logic [31:0]                         prdata,
  output logic                                pready,
  output logic                                pslverr,
  // pins
  input  logic [gpio_width-1:0]               pin_in,
  output logic [gpio_width-1:0]               pin_out,
  output logic [gpio_width-1:0]               pin_oe_n,
  input  logic                                test_tristate, // all drivers off
  output logic [gpio_width-1:0]               interrupt
);

  // port stage to register unit
  logic                                reg_read;
  logic                                reg_write;
  logic [gpio_pkg::gpio_addr_width-1:0] reg_addr;
  logic [31:0]                         reg_wdata;
  logic [31:0]                         reg_rdata;

  // input chain to register unit
  logic [gpio_width-1:0]               input_value;
  logic [gpio_width-1:0]               rise_event;

  apb_gpio_port u_port
  (
    .pclk14    (pclk14),
    .n_reset14 (n_reset14),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .reg_read  (reg_read),
    .reg_write (reg_write),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata)
  );

  gpio_input_sync #(.gpio_width(gpio_width)) u_input_sync
  (
    .pclk14      (pclk14),
    .n_reset14   (n_reset14),
    .pin_in      (pin_in),
    .input_value (input_value),
    .rise_event  (rise_event)
  );

  gpio_lite_subunit #(.gpio_width(gpio_width)) u_subunit
  (
    .pclk14        (pclk14),
    .n_reset14     (n_reset14),
    .reg_read      (reg_read),
    .reg_write     (reg_write),
    .reg_addr      (reg_addr),
    .reg_wdata     (reg_wdata),
    .reg_rdata     (reg_rdata),
    .input_value   (input_value),
    .rise_event    (rise_event),
    .test_tristate (test_tristate),
    .interrupt     (interrupt),
    .pin_out       (pin_out),
    .pin_oe_n      (pin_oe_n)
  );

endmodule : gpio_lite

// File: bench/gpio_model.svh
// reference model for the gpio testbench
// register state, pin edge tracking, bus decode and the lcg
`ifndef gpio_model_svh
`define gpio_model_svh

logic [31:0] lcg_state;         // generator state
logic [31:0] m_direction;       // 1 input, 0 output
logic [31:0] m_output_enable;
logic [31:0] m_output_value;
logic [31:0] m_status;          // sticky rise flags
logic [31:0] m_pins;            // last pattern on pin_in

// lcg step with halves swapped so low bits come from the upper state
function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return {lcg_state[15:0], lcg_state[31:16]};
endfunction

function automatic void model_reset();
  m_direction     = '0;
  m_output_enable = '0;
  m_output_value  = '0;
  m_status        = '0;
  m_pins          = '0;
endfunction

// ---------------------------------------------------------------------------
// bus decode
// ---------------------------------------------------------------------------

function automatic logic model_error(input logic write, input logic [gpio_addr_width-1:0] a);
  logic writable;
  logic legal;
  writable = (a == gpr_direction_mode) || (a == gpr_output_enable) || (a == gpr_output_value);
  legal    = writable || (a == gpr_input_value) || (a == gpr_int_status);
  return write ? !writable : !legal;   // read only offsets refuse writes
endfunction

function automatic void model_write(input logic [gpio_addr_width-1:0] a, input logic [31:0] d);
  if (a == gpr_direction_mode) m_direction = d & pin_mask;
  if (a == gpr_output_enable)  m_output_enable = d & pin_mask;
  if (a == gpr_output_value)   m_output_value = d & pin_mask;
endfunction

function automatic logic [31:0] model_read(input logic [gpio_addr_width-1:0] a);
  logic [31:0] r;
  r = '0;
  if (a == gpr_direction_mode) r = m_direction;
  if (a == gpr_output_enable)  r = m_output_enable;
  if (a == gpr_output_value)   r = m_output_value;
  if (a == gpr_input_value)    r = m_pins;
  if (a == gpr_int_status)
  begin
    r = m_status;
    m_status = '0;     // clear on read
  end
  return r;
endfunction

// new pattern on the pins
// rising edges flag only on input pins
function automatic void model_pins(input logic [31:0] pins);
  m_status = m_status | (pins & ~m_pins & m_direction & pin_mask);
  m_pins   = pins & pin_mask;
endfunction

// a pin drives only when enabled, in output mode and not in test
function automatic logic [31:0] model_oe_n(input logic tristate);
  logic [31:0] oe_n;
  oe_n = '0;
  for (int i = 0; i < gpio_width; i++)
  begin
    if (m_output_enable[i] && !m_direction[i] && !tristate)
      oe_n[i] = 1'b0;   // driver on
    else
      oe_n[i] = 1'b1;
  end
  return oe_n;
endfunction

`endif

// File: bench/tb_gpio_lite.sv
// testbench for the apb gpio block
// clock and reset, apb driver tasks, random test sequences against a model

`timescale 1ns/1ps

module tb_gpio_lite;

  import gpio_pkg::*;

  localparam int gpio_width = 16;
  localparam logic [31:0] pin_mask = 32'hffff_ffff >> (32 - gpio_width);
  localparam int n_rw = 24, n_drive = 12, n_in = 16, n_int = 12, n_err = 12;
  localparam int total_txn = 5 + 2 * n_rw + 3 * n_drive + 1 + n_in + 1 + 3 * n_int + 6 * n_err;
  localparam int cycle_limit = 40 * total_txn;   // generous per transfer

  logic pclk14, n_reset14, psel, penable, pwrite, pready, pslverr, test_tristate;
  logic [gpio_addr_width-1:0] paddr;
  logic [31:0] pwdata, prdata;
  logic [gpio_width-1:0] pin_in, pin_out, pin_oe_n, interrupt;
  int errors = 0, checks = 0, cycle_count = 0;

  `include "gpio_model.svh"

  gpio_lite #(.gpio_width(gpio_width)) UUT
  (
    .pclk14(pclk14), .n_reset14(n_reset14), .psel(psel), .penable(penable),
    .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
    .pready(pready), .pslverr(pslverr), .pin_in(pin_in), .pin_out(pin_out),
    .pin_oe_n(pin_oe_n), .test_tristate(test_tristate), .interrupt(interrupt)
  );

  initial
  begin
    pclk14 = 1'b0;
    forever #2 pclk14 = ~pclk14;   // 4 ns period
  end

  always @(posedge pclk14)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit)
    begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Testbench failed");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("mismatch %s expected %h actual %h", name, exp, act);
    end
  endtask

  // ---------------------------------------------------------------------------
  // apb driver
  // inputs change on the falling edge and are sampled 1 ns later
  // ---------------------------------------------------------------------------

  task automatic apb_transfer(input logic write, input logic [gpio_addr_width-1:0] a,
                              input logic [31:0] d, output logic [31:0] rdata,
                              output logic err, output int waits);
    @(negedge pclk14);
    psel = 1'b1;      // setup cycle
    penable = 1'b0;
    pwrite = write;
    paddr = a;
    pwdata = d;
    @(negedge pclk14);
    penable = 1'b1;   // first access cycle
    waits = 0;
    #1;
    while (!pready)
    begin
      waits++;
      @(negedge pclk14);
      #1;
    end
    rdata = prdata;
    err = pslverr;
    @(negedge pclk14);   // transfer closed at the last rising edge
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_write(input string name, input logic [gpio_addr_width-1:0] a,
                           input logic [31:0] d);
    logic [31:0] rdata;
    logic err;
    int waits;
    apb_transfer(1'b1, a, d, rdata, err, waits);
    if (waits != 0)
    begin
      errors++;
      $display("%s: write to %h took %0d wait states instead of none", name, a, waits);
    end
    check_value({name, " pslverr"}, 32'(model_error(1'b1, a)), 32'(err));
    if (!model_error(1'b1, a))
      model_write(a, d);   // errored writes change nothing
  endtask

  task automatic apb_read(input string name, input logic [gpio_addr_width-1:0] a);
    logic [31:0] rdata;
    logic [31:0] exp;
    logic err;
    int waits;
    exp = model_error(1'b0, a) ? 32'h0 : model_read(a);
    apb_transfer(1'b0, a, 32'h0, rdata, err, waits);
    if (waits != 1)
    begin
      errors++;
      $display("%s: read of %h took %0d wait states instead of one", name, a, waits);
    end
    check_value({name, " pslverr"}, 32'(model_error(1'b0, a)), 32'(err));
    check_value({name, " prdata"}, exp, rdata);
  endtask

  function automatic logic [gpio_addr_width-1:0] writable_addr(input logic [31:0] r);
    case (r[1:0])
      2'd0:    return gpr_direction_mode;
      2'd1:    return gpr_output_enable;
      default: return gpr_output_value;   // value gets a double share
    endcase
  endfunction

  function automatic logic [gpio_addr_width-1:0] unmapped_addr();
    logic [31:0] r;
    r = lcg_next();
    while (!model_error(1'b0, r[gpio_addr_width-1:0]))
      r = lcg_next();   // redraw until off the map
    return r[gpio_addr_width-1:0];
  endfunction

  task automatic set_pins(input logic [31:0] pattern);
    @(negedge pclk14);
    pin_in = pattern[gpio_width-1:0];
    model_pins(pattern);
    repeat (6) @(negedge pclk14);   // through sync, capture and status
  endtask

  task automatic check_pins(input logic tristate);
    @(negedge pclk14);
    test_tristate = tristate;
    #1;
    check_value("pin_out", m_output_value, 32'(pin_out));
    check_value("pin_oe_n", model_oe_n(tristate), 32'(pin_oe_n));
  endtask

  // ---------------------------------------------------------------------------
  // test sequence
  // ---------------------------------------------------------------------------

  initial
  begin
    lcg_state = 32'hfacbd7d9;
    model_reset();
    n_reset14 = 1'b0;
    {psel, penable, pwrite, test_tristate} = 4'b0000;
    paddr = '0;
    pwdata = '0;
    pin_in = '0;
    repeat (2) @(posedge pclk14);
    @(negedge pclk14);
    n_reset14 = 1'b1;
    #1;
    // reset values, idle bus
    check_value("reset pready", 32'h0, 32'(pready));
    check_value("reset pslverr", 32'h0, 32'(pslverr));
    check_value("reset prdata", 32'h0, prdata);
    check_value("reset pin_out", 32'h0, 32'(pin_out));
    check_value("reset pin_oe_n", pin_mask, 32'(pin_oe_n));
    check_value("reset interrupt", 32'h0, 32'(interrupt));
    apb_read("reset direction", gpr_direction_mode);
    apb_read("reset output_enable", gpr_output_enable);
    apb_read("reset output_value", gpr_output_value);
    apb_read("reset input_value", gpr_input_value);
    apb_read("reset int_status", gpr_int_status);
    for (int i = 0; i < n_rw; i++)
    begin
      paddr = writable_addr(lcg_next());   // held until the next setup cycle
      apb_write("register_rw", paddr, lcg_next());
      apb_read("register_rw", paddr);
    end
    for (int i = 0; i < n_drive; i++)
    begin
      apb_write("pin_drive", gpr_direction_mode, lcg_next());
      apb_write("pin_drive", gpr_output_enable, lcg_next());
      apb_write("pin_drive", gpr_output_value, lcg_next());
      check_pins(1'b0);
      check_pins(1'b1);   // every driver forced off
    end
    check_pins(1'b0);
    apb_write("input_sampling", gpr_direction_mode, lcg_next());
    for (int i = 0; i < n_in; i++)
    begin
      set_pins(lcg_next());
      apb_read("input_sampling", gpr_input_value);
    end
    apb_read("interrupt clear", gpr_int_status);   // drop earlier flags
    for (int i = 0; i < n_int; i++)
    begin
      apb_write("interrupt", gpr_direction_mode, lcg_next());
      set_pins(lcg_next());
      #1;
      check_value("interrupt line", m_status, 32'(interrupt));
      apb_read("interrupt status", gpr_int_status);
      apb_read("interrupt second read", gpr_int_status);   // pins stable so status is zero
    end
    for (int i = 0; i < n_err; i++)
    begin
      apb_read("error read", unmapped_addr());
      paddr = lcg_next() % 2 == 0 ? unmapped_addr() :
              (lcg_next() % 2 == 0 ? gpr_input_value : gpr_int_status);
      apb_write("error write", paddr, lcg_next());
      apb_read("error direction", gpr_direction_mode);
      apb_read("error output_enable", gpr_output_enable);
      apb_read("error output_value", gpr_output_value);
      apb_read("error int_status", gpr_int_status);
    end
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule : tb_gpio_lite

// File: src.f
+incdir+bench
hw/gpio_pkg.sv
hw/apb_gpio_port.sv
hw/gpio_input_sync.sv
hw/gpio_lite_subunit.sv
hw/gpio_lite.sv
bench/tb_gpio_lite.sv

// File: run_sim.sh
#!/bin/sh
# build and run the gpio testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_gpio_lite -f src.f \
  --Mdir obj_dir -o tb_gpio_lite > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_gpio_lite > sim.log 2>&1
cat sim.log
grep -q "Testbench failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Testbench passed" sim.log || { echo "simulation gave no result"; exit 1; }
echo "simulation ok"
exit 0
